//--- uart_loopback.f
+incdir+source
source/uart_loopback_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/loopback_ctrl.sv
source/uart_loopback_top.sv
dv/uart_loopback_assertions.sv
dv/uart_loopback_tb.sv

//--- dv/uart_loopback_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_loopback_consts.svh"

module uart_loopback_tb
    import uart_loopback_pkg::*;
();

    localparam int clks_per_bit   = `UART_CLKS_PER_BIT;
    localparam int parity_en      = `UART_PARITY_EN;
    localparam int parity_odd     = `UART_PARITY_ODD;
    localparam int startup_cycles = `LOOPBACK_STARTUP_CYCLES;
    localparam int guard_cycles   = `LOOPBACK_GUARD_CYCLES;
    // start, 8 data, optional parity, stop
    localparam int frame_cycles   = clks_per_bit * (10 + parity_en);
    // longest wait for an echo start edge
    localparam int recv_limit     = 2 * frame_cycles + guard_cycles;
    // 1 + 32 + 20 + 2 + 2 frames, two startups
    localparam int num_frames     = 57;
    localparam int timeout_cycles =
        2 * (2 * startup_cycles + num_frames * (2 * frame_cycles + guard_cycles));

    logic clk;
    logic rst_n;
    logic rx_line;
    logic tx_line;
    logic led_ready;
    logic led_error;
    logic led_activity;

    int          cycle_count;
    // echoes since the last reset
    int          echo_count;

    uart_loopback_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_line      (rx_line),
        .tx_line      (tx_line),
        .led_ready    (led_ready),
        .led_error    (led_error),
        .led_activity (led_activity)
    );

    bind uart_loopback_top uart_loopback_assertions u_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .tx_line   (tx_line),
        .rx_valid  (rx_valid),
        .led_error (led_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit and bound checker watch
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            $display("TESTS FAILED");
            $fatal(1, "cycle limit reached");
        end else if (uut.u_assert.fail_count != 0) begin
            $display("an assertion in the bound checker failed");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        echo_count = 0;
    endtask

    // one bit on rx_line, held a full bit time
    task automatic drive_bit(input logic b);
        rx_line <= b;
        repeat (clks_per_bit) @(posedge clk);
    endtask

    task automatic send_frame(input uart_byte_t data, input logic bad_parity,
                              input logic bad_stop);
        logic parity_bit;
        // even parity makes the ones count even, odd sense flips it
        parity_bit = (^data) ^ parity_odd[0];
        if (bad_parity) begin
            parity_bit = ~parity_bit;
        end
        @(posedge clk);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        if (parity_en != 0) begin
            drive_bit(parity_bit);
        end
        drive_bit(~bad_stop);
        // back to idle, matters after a low stop bit
        rx_line <= 1'b1;
    endtask

    // sampled on the falling clock edge, tx_line moves on the rising one
    task automatic recv_frame(output uart_byte_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (tx_line === 1'b1) begin
            if (waited >= recv_limit) begin
                $display("no start bit on tx_line within %0d cycles", recv_limit);
                $display("TESTS FAILED");
                $fatal(1, "echo missing");
            end
            @(negedge clk);
            waited++;
        end
        // first low sample sits half a cycle into the start bit
        repeat (clks_per_bit / 2) @(negedge clk);
        check_value(tx_line, 1'b0, "start bit at mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[i] = tx_line;
        end
        if (parity_en != 0) begin
            repeat (clks_per_bit) @(negedge clk);
            check_value(tx_line, (^data) ^ parity_odd[0], "parity bit");
        end
        repeat (clks_per_bit) @(negedge clk);
        check_value(tx_line, 1'b1, "stop bit");
    endtask

    task automatic expect_silence();
        repeat (2 * frame_cycles) begin
            @(negedge clk);
            if (tx_line !== 1'b1) begin
                $display("tx_line went low although no echo was expected");
                $display("TESTS FAILED");
                $fatal(1, "unexpected echo");
            end
        end
    endtask

    // rest of the stop bit, guard wait and some margin
    task automatic wait_guard();
        repeat (clks_per_bit / 2 + guard_cycles + 8) @(posedge clk);
    endtask

    task automatic echo_byte(input uart_byte_t data);
        uart_byte_t got;
        fork
            send_frame(data, 1'b0, 1'b0);
            recv_frame(got);
        join
        check_value(got, data, "echoed byte");
        echo_count++;
        wait_guard();
        // one toggle per finished echo
        check_value(led_activity, echo_count % 2, "led_activity");
    endtask

    // called right after reset release, first sample half a cycle later
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!led_ready) begin
            check_value(tx_line, 1'b1, "tx_line during startup");
            check_value({led_error, led_activity}, 2'b00, "leds during startup");
            if (n > startup_cycles + 8) begin
                $display("led_ready did not rise after the startup delay");
                $display("TESTS FAILED");
                $fatal(1, "startup stuck");
            end
            @(negedge clk);
            n++;
        end
        check_value(n >= startup_cycles, 1'b1, "startup delay too short");
    endtask

    task automatic test_reset_startup();
        apply_reset();
        // nothing may leave the board before ready
        wait_ready();
    endtask

    task automatic test_single_echo();
        echo_byte(8'h5a);
        check_value(led_activity, 1'b1, "led_activity after first echo");
    endtask

    task automatic test_ascending();
        for (int i = 0; i < 32; i++) begin
            echo_byte(uart_byte_t'(i));
            check_value(led_error, 1'b0, "led_error in ascending run");
        end
    endtask

    task automatic test_random();
        uart_byte_t data;
        for (int i = 0; i < 20; i++) begin
            data = uart_byte_t'($urandom());
            echo_byte(data);
        end
        check_value(led_activity, echo_count % 2, "led_activity after random run");
    endtask

    task automatic test_parity_error();
        fork
            send_frame(8'hc3, 1'b1, 1'b0);
            expect_silence();
        join
        check_value(led_error, 1'b1, "led_error after parity error");
        echo_byte(8'h81);
        check_value(led_error, 1'b1, "led_error stays set");
    endtask

    task automatic test_framing_error();
        apply_reset();
        wait_ready();
        check_value(led_error, 1'b0, "led_error cleared by reset");
        fork
            send_frame(8'h3c, 1'b0, 1'b1);
            expect_silence();
        join
        check_value(led_error, 1'b1, "led_error after framing error");
        echo_byte(8'ha5);
    endtask

    initial begin
        rst_n       = 1'b0;
        rx_line     = 1'b1;
        cycle_count = 0;
        echo_count  = 0;
        void'($urandom(32'he537_85f5));
        test_reset_startup();
        test_single_echo();
        test_ascending();
        test_random();
        test_parity_error();
        test_framing_error();
        if (uut.u_assert.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("an assertion in the bound checker failed");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

`default_nettype wire

//--- dv/uart_loopback_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loopback_assertions (
    input logic clk,
    input logic rst_n,
    input logic tx_start,
    input logic tx_busy,
    input logic tx_line,
    input logic rx_valid,
    input logic led_error
);

    // failures seen so far, read back by the testbench
    int unsigned fail_count = 0;

    // byte only handed over while the transmitter is free
    start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy
    ) else begin
        fail_count++;
        $error("tx_start raised while tx_busy is high");
    end

    // line idles high between frames
    line_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx_line
    ) else begin
        fail_count++;
        $error("tx_line low while tx_busy is low");
    end

    // receiver result is a single pulse
    valid_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid
    ) else begin
        fail_count++;
        $error("rx_valid high for two cycles");
    end

    // error led only cleared by reset
    error_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$fell(led_error)
    ) else begin
        fail_count++;
        $error("led_error fell without reset");
    end

endmodule

`default_nettype wire

//--- source/uart_loopback_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loopback_top
    import uart_loopback_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic rx_line,
    output logic tx_line,
    output logic led_ready,
    output logic led_error,
    output logic led_activity
);

    // receiver result
    rx_frame_t  rx_frame;
    logic       rx_valid;

    // controller to transmitter
    uart_byte_t tx_data;
    logic       tx_start;
    logic       tx_busy;

    uart_rx u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_line  (rx_line),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

    loopback_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_frame     (rx_frame),
        .rx_valid     (rx_valid),
        .tx_busy      (tx_busy),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .led_ready    (led_ready),
        .led_error    (led_error),
        .led_activity (led_activity)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_line  (tx_line),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

//--- source/loopback_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_loopback_consts.svh"

module loopback_ctrl
    import uart_loopback_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  rx_frame_t  rx_frame,
    input  logic       rx_valid,
    input  logic       tx_busy,
    output logic       tx_start,
    output uart_byte_t tx_data,
    output logic       led_ready,
    output logic       led_error,
    output logic       led_activity
);

    localparam int startup_cycles = `LOOPBACK_STARTUP_CYCLES;
    localparam int guard_cycles   = `LOOPBACK_GUARD_CYCLES;
    // one counter serves both waits, sized for the longer one
    localparam int max_cycles =
        (startup_cycles > guard_cycles) ? startup_cycles : guard_cycles;
    localparam int cnt_w = $clog2(max_cycles + 1);
    localparam logic [cnt_w-1:0] startup_last = cnt_w'(startup_cycles - 1);
    localparam logic [cnt_w-1:0] guard_last   = cnt_w'(guard_cycles - 1);

    ctrl_state_t      state;
    logic [cnt_w-1:0] cnt;
    logic             frame_bad;

    assign frame_bad = rx_frame.parity_err | rx_frame.frame_err;

    // ready once the startup wait is over
    assign led_ready = (state != CTRL_STARTUP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= CTRL_STARTUP;
            cnt          <= '0;
            tx_start     <= 1'b0;
            led_error    <= 1'b0;
            led_activity <= 1'b0;
        end else begin
            // start is a single-cycle pulse
            tx_start <= 1'b0;

            case (state)
                CTRL_STARTUP: begin
                    if (cnt == startup_last) begin
                        cnt   <= '0;
                        state <= CTRL_LISTEN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                CTRL_LISTEN: begin
                    if (rx_valid) begin
                        if (frame_bad) begin
                            // sticky until reset, no echo
                            led_error <= 1'b1;
                        end else begin
                            tx_start <= 1'b1;
                            state    <= CTRL_START;
                        end
                    end
                end
                CTRL_START: begin
                    // wait for the transmitter to take the byte
                    if (tx_busy) begin
                        state <= CTRL_SENDING;
                    end
                end
                CTRL_SENDING: begin
                    if (!tx_busy) begin
                        led_activity <= ~led_activity;
                        cnt          <= '0;
                        state        <= CTRL_GUARD;
                    end
                end
                CTRL_GUARD: begin
                    // input arriving here is dropped
                    if (cnt == guard_last) begin
                        cnt   <= '0;
                        state <= CTRL_LISTEN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    cnt   <= '0;
                    state <= CTRL_STARTUP;
                end
            endcase
        end
    end

    // echo byte, held stable for the whole transmission
    always_ff @(posedge clk) begin
        if (state == CTRL_LISTEN && rx_valid && !frame_bad) begin
            tx_data <= rx_frame.data;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_loopback_consts.svh"

module uart_rx
    import uart_loopback_pkg::*;
#(
    parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rx_line,
    output rx_frame_t rx_frame,
    output logic      rx_valid
);

    localparam bit parity_en  = `UART_PARITY_EN;
    localparam bit parity_odd = `UART_PARITY_ODD;
    localparam int cnt_w      = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
    // mid-bit point of the start bit, counted from the falling edge
    localparam logic [cnt_w-1:0] half_last =
        cnt_w'((clks_per_bit / 2 > 0) ? clks_per_bit / 2 - 1 : 0);

    // two-flop synchronizer plus one stage for edge detection
    logic [1:0] sync_q;
    logic       rx_s;
    logic       rx_prev;
    logic       fall;

    rx_state_t        state;
    logic [cnt_w-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift_q;
    logic             parity_err_q;

    assign rx_s = sync_q[1];
    assign fall = rx_prev & ~rx_s;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // line idles high
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[0], rx_line};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            bit_cnt  <= bit_cnt + 1'b1;

            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (bit_cnt == half_last) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // still low at mid-bit, otherwise a glitch
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_cnt == bit_last) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= parity_en ? RX_PARITY : RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_cnt == bit_last) begin
                        bit_cnt <= '0;
                        state   <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_cnt == bit_last) begin
                        // frame reported the cycle after the stop sample
                        rx_valid <= 1'b1;
                        state    <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // data shifter, parity check and result register
    always_ff @(posedge clk) begin
        if (state == RX_START && bit_cnt == half_last) begin
            parity_err_q <= 1'b0;
        end
        if (state == RX_DATA && bit_cnt == bit_last) begin
            // lsb arrives first
            shift_q <= {rx_s, shift_q[7:1]};
        end
        if (state == RX_PARITY && bit_cnt == bit_last) begin
            // data xor parity bit must match the configured sense
            parity_err_q <= (^shift_q) ^ rx_s ^ parity_odd;
        end
        if (state == RX_STOP && bit_cnt == bit_last) begin
            rx_frame.data       <= shift_q;
            rx_frame.parity_err <= parity_err_q;
            rx_frame.frame_err  <= ~rx_s;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_loopback_consts.svh"

module uart_tx
    import uart_loopback_pkg::*;
#(
    parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  uart_byte_t tx_data,
    output logic       tx_line,
    output logic       tx_busy
);

    localparam bit parity_en  = `UART_PARITY_EN;
    localparam bit parity_odd = `UART_PARITY_ODD;
    localparam int cnt_w      = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

    tx_state_t        state;
    logic [cnt_w-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift_q;
    // running parity of the bits already sent
    logic             parity_q;

    // end of the current bit time
    logic bit_end;
    assign bit_end = (bit_cnt == bit_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_line <= 1'b1;
            tx_busy <= 1'b0;
        end else begin
            // bit timer runs outside idle, wraps each bit
            if (state == TX_IDLE || bit_end) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    if (tx_start) begin
                        // start bit goes out next cycle
                        tx_line <= 1'b0;
                        tx_busy <= 1'b1;
                        state   <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        // first data bit, lsb first
                        tx_line <= shift_q[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx_line <= parity_en ? parity_q : 1'b1;
                            state   <= parity_en ? TX_PARITY : TX_STOP;
                        end else begin
                            tx_line <= shift_q[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end) begin
                        tx_line <= 1'b1;
                        state   <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    // busy drops exactly at the end of the stop bit
                    if (bit_end) begin
                        tx_busy <= 1'b0;
                        state   <= TX_IDLE;
                    end
                end
                default: begin
                    tx_line <= 1'b1;
                    tx_busy <= 1'b0;
                    state   <= TX_IDLE;
                end
            endcase
        end
    end

    // byte shifter and parity accumulator
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shift_q  <= tx_data;
            // seed with the sense so the final value is the parity bit
            parity_q <= parity_odd;
        end else if (bit_end && (state == TX_START ||
                     (state == TX_DATA && bit_idx != 3'd7))) begin
            parity_q <= parity_q ^ shift_q[0];
            shift_q  <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- source/uart_loopback_pkg.sv
`default_nettype none

package uart_loopback_pkg;

    // one data byte on the serial line
    typedef logic [7:0] uart_byte_t;

    // completed frame as seen by the receiver
    // error flags travel with the byte, the controller decides
    typedef struct packed {
        uart_byte_t data;
        logic       parity_err;
        logic       frame_err;
    } rx_frame_t;

    // receiver fsm
    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_t;

    // transmitter fsm
    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_t;

    // echo controller fsm
    typedef enum logic [2:0] {
        CTRL_STARTUP, CTRL_LISTEN, CTRL_START, CTRL_SENDING, CTRL_GUARD
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/uart_loopback_consts.svh
`ifndef UART_LOOPBACK_CONSTS_SVH
`define UART_LOOPBACK_CONSTS_SVH

// serial bit timing
// clock cycles per bit on both lines
`define UART_CLKS_PER_BIT 8

// parity options
// 1 when a parity bit follows the eight data bits
`define UART_PARITY_EN 1
// 1 for odd parity, 0 for even
`define UART_PARITY_ODD 0

// controller timing
// cycles after reset before echo is enabled
`define LOOPBACK_STARTUP_CYCLES 64

// idle cycles after each echo before listening again
// gives the far end time to check the echo
`define LOOPBACK_GUARD_CYCLES 30

`endif
